// File: hw/filter_settings.svh
`ifndef FILTER_SETTINGS_SVH
`define FILTER_SETTINGS_SVH

// Audio sample and coefficient widths
`define FILTER_DATA_W    8
`define FILTER_COEFF_W   10

// Full tap count and the stored half including the centre tap
`define FILTER_TAPS      31
`define FILTER_HALF_TAPS 16

// Tap index width, enough for 0 to 30
`define FILTER_IDX_W     5

// Holds 31 products of 8 by 10 bits
`define FILTER_ACC_W     23

// Common scaling before saturation to the sample width
`define FILTER_OUT_SHIFT 9

`endif

// File: hw/filter_pkg.sv
`default_nettype none
`include "filter_settings.svh"

package filter_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        mode_lpf  = 2'd0,
        mode_hpf  = 2'd1,
        mode_bpf1 = 2'd2,
        mode_bpf2 = 2'd3
    } filter_mode_e;

    typedef enum logic [1:0] {
        fir_idle,
        fir_load,
        fir_mac,
        fir_finish
    } fir_state_e;

    // Shared by both sides of the four-phase links
    typedef enum logic [1:0] {
        hs_idle,
        hs_active,
        hs_release
    } hs_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // Link payloads
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        filter_mode_e                     mode;
        logic signed [`FILTER_DATA_W-1:0] data;
    } audio_sample_t;

    typedef struct packed {
        filter_mode_e                     mode;
        logic signed [`FILTER_DATA_W-1:0] data;
    } filtered_sample_t;

    ////////////////////////////////////////////////////////////////////////////
    // Half tables, entry 15 is the centre tap
    ////////////////////////////////////////////////////////////////////////////

    localparam logic signed [`FILTER_COEFF_W-1:0]
        filter_half_taps [4][`FILTER_HALF_TAPS] = '{
        // Low-pass
        '{  -2,  -3,  -4,  -4,  -2,   2,   8,  16,
            26,  38,  50,  62,  72,  80,  85,  87},
        // High-pass
        '{   1,   2,   3,   3,   1,  -2,  -6, -11,
           -17, -22, -27, -31, -34, -36, -37, 380},
        // Band-pass 1
        '{   3,   1,  -4,  -8,  -6,   3,  14,  18,
             8, -14, -34, -36, -12,  26,  58,  70},
        // Band-pass 2
        '{  -4,   6,   2, -10,   4,  14, -12, -14,
            22,  10, -34,   0,  44, -14, -50,  56}
    };

endpackage

`default_nettype wire

// File: hw/sample_receiver.sv
`default_nettype none
`timescale 1ns/1ps

module sample_receiver import filter_pkg::*; (
    input  logic          clock,
    input  logic          rst,
    input  logic          in_req,
    output logic          in_ack,
    input  audio_sample_t in_sample,
    output logic          rx_valid,
    output audio_sample_t rx_sample,
    input  logic          rx_take
);

    hs_state_e state;
    logic      accept;

    // Only acknowledge into an empty buffer
    assign accept = (state == hs_idle) && in_req && !rx_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase handshake and buffer flag
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= hs_idle;
            in_ack   <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            case (state)
                hs_idle: begin
                    if (accept) begin
                        in_ack <= 1'b1;
                        state  <= hs_active;
                    end
                end
                hs_active: begin
                    // Source has dropped its request
                    if (!in_req) begin
                        in_ack <= 1'b0;
                        state  <= hs_idle;
                    end
                end
                default: begin
                    in_ack <= 1'b0;
                    state  <= hs_idle;
                end
            endcase

            if (accept) begin
                rx_valid <= 1'b1;
            end else if (rx_take) begin
                rx_valid <= 1'b0;
            end
        end
    end

    // Sample held until control takes it
    always_ff @(posedge clock) begin
        if (accept) begin
            rx_sample <= in_sample;
        end
    end

endmodule

`default_nettype wire

// File: hw/filter_coeffs.sv
`default_nettype none
`timescale 1ns/1ps
`include "filter_settings.svh"

module filter_coeffs import filter_pkg::*; (
    input  logic                              clock,
    input  filter_mode_e                      coeff_mode,
    input  logic [`FILTER_IDX_W-1:0]          coeff_index,
    output logic signed [`FILTER_COEFF_W-1:0] coeff
);

    localparam int                      HALF_W = $clog2(`FILTER_HALF_TAPS);
    localparam logic [`FILTER_IDX_W-1:0] CENTRE = `FILTER_HALF_TAPS - 1;
    localparam logic [`FILTER_IDX_W-1:0] LAST   = `FILTER_TAPS - 1;

    logic [`FILTER_IDX_W-1:0] folded;
    logic [HALF_W-1:0]        half_index;

    // Taps above the centre mirror back onto the stored half
    always_comb begin
        if (coeff_index > CENTRE) begin
            folded = LAST - coeff_index;
        end else begin
            folded = coeff_index;
        end
    end

    assign half_index = folded[HALF_W-1:0];

    // Registered read, one cycle of latency
    always_ff @(posedge clock) begin
        coeff <= filter_half_taps[coeff_mode][half_index];
    end

endmodule

`default_nettype wire

// File: hw/fir31.sv
`default_nettype none
`timescale 1ns/1ps
`include "filter_settings.svh"

module fir31 import filter_pkg::*; (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              fir_start,
    input  logic signed [`FILTER_DATA_W-1:0]  fir_sample,
    input  filter_mode_e                      fir_mode,
    output logic                              fir_done,
    output logic signed [`FILTER_ACC_W-1:0]   fir_acc,
    output filter_mode_e                      coeff_mode,
    output logic [`FILTER_IDX_W-1:0]          coeff_index,
    input  logic signed [`FILTER_COEFF_W-1:0] coeff
);

    localparam int                      PROD_W   = `FILTER_DATA_W + `FILTER_COEFF_W;
    localparam logic [`FILTER_IDX_W-1:0] LAST_TAP = `FILTER_TAPS - 1;

    fir_state_e                       state;
    filter_mode_e                     mode_q;
    logic [`FILTER_IDX_W-1:0]         idx;
    logic [`FILTER_IDX_W-1:0]         pos;
    logic signed [`FILTER_DATA_W-1:0] history [`FILTER_TAPS];
    logic signed [`FILTER_ACC_W-1:0]  acc;
    logic signed [PROD_W-1:0]         product;
    logic                             take;

    assign take        = (state == fir_idle) && fir_start;
    assign coeff_mode  = mode_q;
    assign coeff_index = idx;
    assign fir_acc     = acc;

    // Coefficient at pos arrives one cycle after its index went out
    assign product = history[pos] * coeff;

    ////////////////////////////////////////////////////////////////////////////
    // Sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            state    <= fir_idle;
            fir_done <= 1'b0;
            idx      <= '0;
            pos      <= '0;
        end else begin
            fir_done <= 1'b0;
            case (state)
                fir_idle: begin
                    if (fir_start) begin
                        idx   <= '0;
                        pos   <= '0;
                        state <= fir_load;
                    end
                end
                fir_load: begin
                    // Tap 0 is being read this cycle
                    idx   <= idx + 1'b1;
                    state <= fir_mac;
                end
                fir_mac: begin
                    if (idx != LAST_TAP) begin
                        idx <= idx + 1'b1;
                    end
                    pos <= pos + 1'b1;
                    if (pos == LAST_TAP) begin
                        state <= fir_finish;
                    end
                end
                fir_finish: begin
                    fir_done <= 1'b1;
                    state    <= fir_idle;
                end
                default: state <= fir_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Delay line, shared by all modes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            for (int i = 0; i < `FILTER_TAPS; i++) begin
                history[i] <= '0;
            end
        end else if (take) begin
            history[0] <= fir_sample;
            for (int i = 1; i < `FILTER_TAPS; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

    // Accumulator and latched mode
    always_ff @(posedge clock) begin
        if (take) begin
            mode_q <= fir_mode;
        end
        if (state == fir_load) begin
            acc <= '0;
        end else if (state == fir_mac) begin
            acc <= acc + product;
        end
    end

endmodule

`default_nettype wire

// File: hw/filter_control.sv
`default_nettype none
`timescale 1ns/1ps
`include "filter_settings.svh"

module filter_control import filter_pkg::*; (
    input  logic             clock,
    input  logic             rst,
    input  logic             rx_valid,
    input  audio_sample_t    rx_sample,
    output logic             rx_take,
    output logic             tx_valid,
    output filtered_sample_t tx_sample,
    input  logic             tx_take
);

    localparam logic signed [`FILTER_ACC_W-1:0] SAT_HI = 2**(`FILTER_DATA_W-1) - 1;
    localparam logic signed [`FILTER_ACC_W-1:0] SAT_LO = -(2**(`FILTER_DATA_W-1));

    logic                              fir_start;
    logic                              fir_done;
    logic                              busy;
    logic signed [`FILTER_ACC_W-1:0]   fir_acc;
    logic signed [`FILTER_ACC_W-1:0]   scaled;
    logic signed [`FILTER_DATA_W-1:0]  saturated;
    filter_mode_e                      run_mode;
    filter_mode_e                      coeff_mode;
    logic [`FILTER_IDX_W-1:0]          coeff_index;
    logic signed [`FILTER_COEFF_W-1:0] coeff;

    fir31 fir31_inst (
        .clock       (clock),
        .rst         (rst),
        .fir_start   (fir_start),
        .fir_sample  (rx_sample.data),
        .fir_mode    (rx_sample.mode),
        .fir_done    (fir_done),
        .fir_acc     (fir_acc),
        .coeff_mode  (coeff_mode),
        .coeff_index (coeff_index),
        .coeff       (coeff)
    );

    filter_coeffs filter_coeffs_inst (
        .clock       (clock),
        .coeff_mode  (coeff_mode),
        .coeff_index (coeff_index),
        .coeff       (coeff)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Scale and clip to the sample range
    ////////////////////////////////////////////////////////////////////////////

    assign scaled = fir_acc >>> `FILTER_OUT_SHIFT;

    always_comb begin
        if (scaled > SAT_HI) begin
            saturated = SAT_HI[`FILTER_DATA_W-1:0];
        end else if (scaled < SAT_LO) begin
            saturated = SAT_LO[`FILTER_DATA_W-1:0];
        end else begin
            saturated = scaled[`FILTER_DATA_W-1:0];
        end
    end

    // Start only with the engine idle and the result slot empty
    always_ff @(posedge clock) begin
        if (rst) begin
            fir_start <= 1'b0;
            rx_take   <= 1'b0;
            busy      <= 1'b0;
            tx_valid  <= 1'b0;
        end else begin
            fir_start <= 1'b0;
            rx_take   <= 1'b0;
            if (rx_valid && !busy && !tx_valid) begin
                fir_start <= 1'b1;
                rx_take   <= 1'b1;
                busy      <= 1'b1;
            end else if (fir_done) begin
                busy <= 1'b0;
            end

            if (fir_done) begin
                tx_valid <= 1'b1;
            end else if (tx_take) begin
                tx_valid <= 1'b0;
            end
        end
    end

    // Mode rides alongside the sum
    always_ff @(posedge clock) begin
        if (fir_start) begin
            run_mode <= rx_sample.mode;
        end
        if (fir_done) begin
            tx_sample.mode <= run_mode;
            tx_sample.data <= saturated;
        end
    end

endmodule

`default_nettype wire

// File: hw/sample_sender.sv
`default_nettype none
`timescale 1ns/1ps

module sample_sender import filter_pkg::*; (
    input  logic             clock,
    input  logic             rst,
    input  logic             tx_valid,
    input  filtered_sample_t tx_sample,
    output logic             tx_take,
    output logic             out_req,
    input  logic             out_ack,
    output filtered_sample_t out_sample
);

    hs_state_e state;
    logic      capture;

    assign capture = (state == hs_idle) && tx_valid;

    ////////////////////////////////////////////////////////////////////////////
    // Four-phase source side
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            state   <= hs_idle;
            out_req <= 1'b0;
            tx_take <= 1'b0;
        end else begin
            tx_take <= 1'b0;
            case (state)
                hs_idle: begin
                    if (capture) begin
                        tx_take <= 1'b1;
                        out_req <= 1'b1;
                        state   <= hs_active;
                    end
                end
                hs_active: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= hs_release;
                    end
                end
                hs_release: begin
                    // Wait for the sink to drop its acknowledge
                    if (!out_ack) begin
                        state <= hs_idle;
                    end
                end
                default: state <= hs_idle;
            endcase
        end
    end

    // Held stable through the whole request phase
    always_ff @(posedge clock) begin
        if (capture) begin
            out_sample <= tx_sample;
        end
    end

endmodule

`default_nettype wire

// File: hw/audio_filter_top.sv
`default_nettype none
`timescale 1ns/1ps

module audio_filter_top import filter_pkg::*; (
    input  logic             clock,
    input  logic             rst,
    input  logic             in_req,
    output logic             in_ack,
    input  audio_sample_t    in_sample,
    output logic             out_req,
    input  logic             out_ack,
    output filtered_sample_t out_sample
);

    logic             rx_valid;
    audio_sample_t    rx_sample;
    logic             rx_take;
    logic             tx_valid;
    filtered_sample_t tx_sample;
    logic             tx_take;

    // Input link
    sample_receiver sample_receiver_inst (
        .clock     (clock),
        .rst       (rst),
        .in_req    (in_req),
        .in_ack    (in_ack),
        .in_sample (in_sample),
        .rx_valid  (rx_valid),
        .rx_sample (rx_sample),
        .rx_take   (rx_take)
    );

    // Shared engine for all four filters
    filter_control filter_control_inst (
        .clock     (clock),
        .rst       (rst),
        .rx_valid  (rx_valid),
        .rx_sample (rx_sample),
        .rx_take   (rx_take),
        .tx_valid  (tx_valid),
        .tx_sample (tx_sample),
        .tx_take   (tx_take)
    );

    // Output link
    sample_sender sample_sender_inst (
        .clock      (clock),
        .rst        (rst),
        .tx_valid   (tx_valid),
        .tx_sample  (tx_sample),
        .tx_take    (tx_take),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_sample (out_sample)
    );

endmodule

`default_nettype wire

// File: sim/audio_filter_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module audio_filter_asserts import filter_pkg::*; (
    input logic             clock,
    input logic             rst,
    input logic             in_req,
    input logic             in_ack,
    input audio_sample_t    in_sample,
    input logic             out_req,
    input logic             out_ack,
    input filtered_sample_t out_sample
);

    // Source holds its sample until the receiver acknowledges
    in_sample_stable: assert property (@(posedge clock) disable iff (rst)
        in_req && $past(in_req) && !$past(in_ack) |-> $stable(in_sample))
        else $error("in_sample changed while in_req waited for in_ack");

    // Sender keeps its data fixed through the request phase
    out_sample_stable: assert property (@(posedge clock) disable iff (rst)
        out_req && $past(out_req) |-> $stable(out_sample))
        else $error("out_sample changed while out_req was high");

    out_req_rise: assert property (@(posedge clock) disable iff (rst)
        $rose(out_req) |-> !$past(out_ack))
        else $error("out_req rose while out_ack was still high");

    in_ack_rise: assert property (@(posedge clock) disable iff (rst)
        $rose(in_ack) |-> $past(in_req))
        else $error("in_ack rose without a pending in_req");

endmodule

bind audio_filter_top audio_filter_asserts audio_filter_asserts_inst (
    .clock      (clock),
    .rst        (rst),
    .in_req     (in_req),
    .in_ack     (in_ack),
    .in_sample  (in_sample),
    .out_req    (out_req),
    .out_ack    (out_ack),
    .out_sample (out_sample)
);

`default_nettype wire

// File: sim/audio_filter_tb.sv
`default_nettype none
`timescale 1ns/1ps
`include "filter_settings.svh"

module audio_filter_tb import filter_pkg::*; ();

    // About 530 samples near 40 cycles each and 60 stalled ones up to 100
    localparam int TIMEOUT_CYCLES = 40000;
    localparam logic [31:0] SEED = 32'hbc4e_1ad2;
    localparam int SAT_MAX = 2**(`FILTER_DATA_W-1) - 1;
    localparam int SAT_MIN = -(2**(`FILTER_DATA_W-1));
    localparam logic signed [`FILTER_DATA_W-1:0] IMPULSE    = 8'sh40;
    localparam logic signed [`FILTER_DATA_W-1:0] MAX_SAMPLE = 8'sh7f;
    localparam logic signed [`FILTER_DATA_W-1:0] MIN_SAMPLE = 8'sh80;

    logic             clock;
    logic             rst;
    logic             in_req;
    logic             in_ack;
    audio_sample_t    in_sample;
    logic             out_req;
    logic             out_ack;
    filtered_sample_t out_sample;

    int          cycle_count;
    int          mismatch_count;
    int          other_count;
    int          ack_delay_max;
    logic [31:0] stim_state;
    logic [31:0] ack_state;

    logic signed [`FILTER_DATA_W-1:0] model_hist [`FILTER_TAPS];
    filtered_sample_t                 expected_q [$];
    filtered_sample_t                 received_q [$];

    audio_filter_top audio_filter_top_inst (
        .clock      (clock),
        .rst        (rst),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_sample  (in_sample),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_sample (out_sample)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles with %0d outputs still outstanding",
                     cycle_count, expected_q.size());
            $display("Errors: %0d mismatches, %0d other failures, run timed out",
                     mismatch_count, other_count);
            $display("Test FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Full 31-tap response rebuilt from the stored half
    function automatic int tap_value(input filter_mode_e mode, input int k);
        int half;
        half = (k < `FILTER_HALF_TAPS) ? k : (`FILTER_TAPS - 1 - k);
        return int'(filter_half_taps[mode][half]);
    endfunction

    function automatic int scale_clip(input int acc);
        int v;
        v = acc >>> `FILTER_OUT_SHIFT;
        if (v > SAT_MAX) begin
            v = SAT_MAX;
        end else if (v < SAT_MIN) begin
            v = SAT_MIN;
        end
        return v;
    endfunction

    task automatic update_model(input filter_mode_e mode,
                                input logic signed [`FILTER_DATA_W-1:0] data);
        int               k;
        int               acc;
        int               v;
        filtered_sample_t exp;
        for (k = `FILTER_TAPS - 1; k > 0; k--) begin
            model_hist[k] = model_hist[k-1];
        end
        model_hist[0] = data;
        acc = 0;
        for (k = 0; k < `FILTER_TAPS; k++) begin
            acc = acc + int'(model_hist[k]) * tap_value(mode, k);
        end
        v = scale_clip(acc);
        exp.mode = mode;
        exp.data = v[`FILTER_DATA_W-1:0];
        expected_q.push_back(exp);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Link drivers
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_sample(input filter_mode_e mode,
                               input logic signed [`FILTER_DATA_W-1:0] data);
        update_model(mode, data);
        in_sample.mode = mode;
        in_sample.data = data;
        in_req = 1'b1;
        do begin
            @(posedge clock);
            #1;
        end while (!in_ack);
        in_req = 1'b0;
        do begin
            @(posedge clock);
            #1;
        end while (in_ack);
    endtask

    task automatic check_output(input filtered_sample_t got);
        filtered_sample_t exp;
        received_q.push_back(got);
        assert (expected_q.size() != 0) else begin
            other_count++;
            $display("Output at %0t arrived with no sample outstanding", $time);
        end
        if (expected_q.size() != 0) begin
            exp = expected_q.pop_front();
            assert (got.data == exp.data) else begin
                mismatch_count++;
                $display("Mismatch at %0t: out_sample.data expected %0d, got %0d",
                         $time, exp.data, got.data);
            end
            assert (got.mode == exp.mode) else begin
                mismatch_count++;
                $display("Mismatch at %0t: out_sample.mode expected %s, got %s",
                         $time, exp.mode.name(), got.mode.name());
            end
        end
    endtask

    // Sink side acknowledging after a random stall of up to ack_delay_max
    task automatic answer_output();
        int               delay;
        filtered_sample_t got;
        @(posedge clock);
        #1;
        if (out_req) begin
            got = out_sample;
            delay = 0;
            if (ack_delay_max > 0) begin
                ack_state = next_random(ack_state);
                delay = int'(ack_state % (ack_delay_max + 1));
            end
            repeat (delay) begin
                @(posedge clock);
                #1;
            end
            check_output(got);
            out_ack = 1'b1;
            do begin
                @(posedge clock);
                #1;
            end while (out_req);
            out_ack = 1'b0;
        end
    endtask

    task automatic wait_drained();
        while (expected_q.size() != 0 || out_req || out_ack) begin
            @(posedge clock);
            #1;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic reset_quiet_check();
        assert (!in_ack) else begin
            other_count++;
            $display("in_ack is high right after reset");
        end
        repeat (20) begin
            @(posedge clock);
            #1;
            assert (!out_req) else begin
                other_count++;
                $display("out_req rose at %0t before any sample was sent", $time);
            end
        end
    endtask

    task automatic impulse_per_mode();
        int               m;
        int               k;
        int               exp_v;
        filter_mode_e     mode;
        filtered_sample_t got;
        for (m = 0; m < 4; m++) begin
            mode = filter_mode_e'(m);
            repeat (`FILTER_TAPS) send_sample(mode, '0);
            wait_drained();
            received_q.delete();
            send_sample(mode, IMPULSE);
            repeat (`FILTER_TAPS - 1) send_sample(mode, '0);
            wait_drained();
            assert (received_q.size() == `FILTER_TAPS) else begin
                other_count++;
                $display("Impulse in mode %s gave %0d outputs instead of %0d",
                         mode.name(), received_q.size(), `FILTER_TAPS);
            end
            // Each output walks one tap folded around the centre
            for (k = 0; k < received_q.size() && k < `FILTER_TAPS; k++) begin
                got = received_q[k];
                exp_v = scale_clip(int'(IMPULSE) * tap_value(mode, k));
                assert (int'(got.data) == exp_v) else begin
                    mismatch_count++;
                    $display("Mismatch at %0t: out_sample.data tap %0d expected %0d, got %0d",
                             $time, k, exp_v, got.data);
                end
            end
        end
    endtask

    task automatic saturation_limits();
        filtered_sample_t got;
        received_q.delete();
        repeat (40) send_sample(mode_lpf, MAX_SAMPLE);
        wait_drained();
        got = received_q[$];
        assert (int'(got.data) == SAT_MAX) else begin
            mismatch_count++;
            $display("Mismatch at %0t: out_sample.data expected %0d, got %0d",
                     $time, SAT_MAX, got.data);
        end
        repeat (40) send_sample(mode_lpf, MIN_SAMPLE);
        wait_drained();
        got = received_q[$];
        assert (int'(got.data) == SAT_MIN) else begin
            mismatch_count++;
            $display("Mismatch at %0t: out_sample.data expected %0d, got %0d",
                     $time, SAT_MIN, got.data);
        end
    endtask

    // Random data and modes over the shared history
    task automatic random_stream(input int count, input int max_delay);
        int           n;
        filter_mode_e mode;
        logic signed [`FILTER_DATA_W-1:0] data;
        ack_delay_max = max_delay;
        received_q.delete();
        for (n = 0; n < count; n++) begin
            stim_state = next_random(stim_state);
            mode = filter_mode_e'(stim_state[9:8]);
            data = stim_state[7:0];
            send_sample(mode, data);
        end
        wait_drained();
        assert (received_q.size() == count) else begin
            other_count++;
            $display("Sent %0d samples but received %0d outputs", count, received_q.size());
        end
        ack_delay_max = 0;
    endtask

    initial begin
        wait (!rst);
        forever answer_output();
    end

    initial begin
        clock = 1'b0;
        rst = 1'b1;
        in_req = 1'b0;
        in_sample = '0;
        out_ack = 1'b0;
        cycle_count = 0;
        mismatch_count = 0;
        other_count = 0;
        ack_delay_max = 0;
        stim_state = SEED;
        ack_state = next_random(SEED);
        for (int k = 0; k < `FILTER_TAPS; k++) begin
            model_hist[k] = '0;
        end

        repeat (8) @(posedge clock);
        #1;
        rst = 1'b0;

        reset_quiet_check();
        impulse_per_mode();
        saturation_limits();
        random_stream(200, 0);
        random_stream(60, 60);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
+incdir+hw
hw/filter_pkg.sv
hw/sample_receiver.sv
hw/filter_coeffs.sv
hw/fir31.sv
hw/filter_control.sv
hw/sample_sender.sv
hw/audio_filter_top.sv
sim/audio_filter_asserts.sv
sim/audio_filter_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the audio filter testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f project.f \
    --top-module audio_filter_tb \
    -o audio_filter_sim

./obj_dir/audio_filter_sim | tee "$LOG"

if grep -qx "Test OK" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
